//--- hw/sat_state_pkg.sv
`default_nettype none

package sat_state_pkg;

    // mask vectors are sized for the largest bin
    localparam int MAX_VARS = 16;

    // global decision level
    typedef logic [15:0] lvl_t;

    // level inside one bin, at most 15 variables
    typedef logic [3:0] loc_lvl_t;

    // variable value code
    typedef logic [1:0] var_val_t;

    localparam var_val_t VAL_UNASSIGNED = 2'd0;
    localparam var_val_t VAL_FALSE      = 2'd1;
    localparam var_val_t VAL_TRUE       = 2'd2;

    typedef logic [MAX_VARS-1:0] var_mask_t;

    typedef struct packed {
        var_val_t val;
        logic     implied;
        loc_lvl_t lvl;
    } var_state_t;

    // pol bit 1 means imply true
    typedef struct packed {
        var_mask_t mask;
        var_mask_t pol;
    } imply_req_t;

    // learnt clause, one literal per masked variable
    typedef struct packed {
        var_mask_t mask;
        var_mask_t pol;
    } clause_t;

    typedef enum logic [1:0] {
        ANALYZE_IDLE = 2'd0,
        FIND_LEARNTC = 2'd1,
        ADD_LEARNTC  = 2'd2,
        ANALYZE_DONE = 2'd3
    } analyze_state_e;

endpackage

`default_nettype wire

//--- hw/decision_decode.sv
`default_nettype none

module decision_decode
    import sat_state_pkg::*;
#(
    parameter int NUM_VARS = 8
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            start_decision_i,
    input  wire var_state_t [NUM_VARS-1:0] var_states_i,
    input  wire                            apply_bkt_i,
    input  wire loc_lvl_t                  bkt_loc_lvl_i,
    output logic                           dec_valid_o,
    output logic [NUM_VARS-1:0]            dec_index_o,
    output loc_lvl_t                       loc_lvl_o,
    output logic                           done_decision_o,
    output logic                           all_assigned_o
);

    logic [NUM_VARS-1:0] free_vec;
    logic [NUM_VARS-1:0] pick;
    logic                any_free;
    loc_lvl_t            loc_lvl_q;

    always_comb begin
        for (int i = 0; i < NUM_VARS; i++) begin
            free_vec[i] = (var_states_i[i].val == VAL_UNASSIGNED);
        end
    end

    // lowest set bit of the free vector
    assign pick     = free_vec & (~free_vec + NUM_VARS'(1));
    assign any_free = |free_vec;

    // nothing to decide when the bin is full
    assign dec_valid_o = start_decision_i & any_free;
    assign dec_index_o = dec_valid_o ? pick : '0;

    // local level counter
    always_ff @(posedge clk) begin
        if (!rst) begin
            loc_lvl_q <= '0;
        end else if (apply_bkt_i) begin
            loc_lvl_q <= bkt_loc_lvl_i;
        end else if (dec_valid_o) begin
            loc_lvl_q <= loc_lvl_q + loc_lvl_t'(1);
        end
    end

    assign loc_lvl_o = loc_lvl_q;

    // done pulses even if no variable was free
    always_ff @(posedge clk) begin
        if (!rst) begin
            done_decision_o <= 1'b0;
        end else begin
            done_decision_o <= start_decision_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            all_assigned_o <= 1'b0;
        end else begin
            all_assigned_o <= ~any_free;
        end
    end

endmodule

`default_nettype wire

//--- hw/var_state_exec.sv
`default_nettype none

module var_state_exec
    import sat_state_pkg::*;
#(
    parameter int NUM_VARS = 8
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       dec_valid_i,
    input  wire [NUM_VARS-1:0]        dec_index_i,
    input  wire loc_lvl_t             loc_lvl_i,
    input  wire                       apply_imply_i,
    input  wire imply_req_t           imply_req_i,
    input  wire                       apply_bkt_i,
    input  wire loc_lvl_t             bkt_loc_lvl_i,
    output var_state_t [NUM_VARS-1:0] var_states_o,
    output logic [NUM_VARS-1:0]       conflict_mask_o,
    output logic                      find_conflict_o,
    output logic                      done_imply_o,
    output logic                      done_bkt_o
);

    var_state_t [NUM_VARS-1:0] state_q;
    var_state_t [NUM_VARS-1:0] state_d;
    var_val_t   [NUM_VARS-1:0] want_val;
    logic       [NUM_VARS-1:0] imply_hit;
    logic       [NUM_VARS-1:0] conflict_hit;
    logic                      quiet_q;

    // per variable implication and conflict
    always_comb begin
        for (int i = 0; i < NUM_VARS; i++) begin
            want_val[i]     = imply_req_i.pol[i] ? VAL_TRUE : VAL_FALSE;
            imply_hit[i]    = apply_imply_i && imply_req_i.mask[i]
                              && (state_q[i].val == VAL_UNASSIGNED);
            conflict_hit[i] = apply_imply_i && imply_req_i.mask[i]
                              && (state_q[i].val != VAL_UNASSIGNED)
                              && (state_q[i].val != want_val[i]);
        end
    end

    always_comb begin
        state_d = state_q;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (apply_bkt_i) begin
                if (state_q[i].lvl > bkt_loc_lvl_i) begin
                    state_d[i].val     = VAL_UNASSIGNED;
                    state_d[i].implied = 1'b0;
                    state_d[i].lvl     = '0;
                end
            end else if (dec_valid_i && dec_index_i[i]) begin
                // decode bumps the level on this same edge
                state_d[i].val     = VAL_FALSE;
                state_d[i].implied = 1'b0;
                state_d[i].lvl     = loc_lvl_i + loc_lvl_t'(1);
            end else if (imply_hit[i]) begin
                state_d[i].val     = want_val[i];
                state_d[i].implied = 1'b1;
                state_d[i].lvl     = loc_lvl_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_VARS; i++) begin
                state_q[i].val     <= VAL_UNASSIGNED;
                state_q[i].implied <= 1'b0;
                state_q[i].lvl     <= '0;
            end
        end else begin
            state_q <= state_d;
        end
    end

    assign var_states_o = state_q;

    // conflict stays until backtrack
    always_ff @(posedge clk) begin
        if (!rst) begin
            conflict_mask_o <= '0;
            find_conflict_o <= 1'b0;
        end else if (apply_bkt_i) begin
            conflict_mask_o <= '0;
            find_conflict_o <= 1'b0;
        end else begin
            conflict_mask_o <= conflict_mask_o | conflict_hit;
            find_conflict_o <= find_conflict_o | (|conflict_hit);
        end
    end

    // done on the first quiet cycle after activity
    always_ff @(posedge clk) begin
        if (!rst) begin
            quiet_q      <= 1'b0;
            done_imply_o <= 1'b0;
        end else begin
            quiet_q      <= apply_imply_i && !(|imply_hit);
            done_imply_o <= apply_imply_i && !(|imply_hit) && !quiet_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            done_bkt_o <= 1'b0;
        end else begin
            done_bkt_o <= apply_bkt_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/bkt_result.sv
`default_nettype none

module bkt_result
    import sat_state_pkg::*;
#(
    parameter int NUM_VARS = 8
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire var_state_t [NUM_VARS-1:0] var_states_i,
    input  wire [NUM_VARS-1:0]             conflict_mask_i,
    input  wire loc_lvl_t                  loc_lvl_i,
    input  wire                            apply_analyze_i,
    input  wire                            base_lvl_en_i,
    input  wire lvl_t                      base_lvl_i,
    output lvl_t                           cur_lvl_o,
    output clause_t                        learnt_o,
    output logic                           add_learntc_en_o,
    output logic                           done_analyze_o,
    output lvl_t                           bkt_lvl_o,
    output logic                           bkt_bin_o,
    output loc_lvl_t                       bkt_loc_lvl_o
);

    lvl_t           base_lvl_q;
    analyze_state_e state_q;
    analyze_state_e state_d;
    clause_t        learnt_d;
    loc_lvl_t       target;
    logic           at_floor;

    always_ff @(posedge clk) begin
        if (!rst) begin
            base_lvl_q <= '0;
        end else if (base_lvl_en_i) begin
            base_lvl_q <= base_lvl_i;
        end
    end

    assign cur_lvl_o = base_lvl_q + lvl_t'(loc_lvl_i);

    // negate every decision literal
    always_comb begin
        learnt_d = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (var_states_i[i].val != VAL_UNASSIGNED && !var_states_i[i].implied) begin
                learnt_d.mask[i] = 1'b1;
                learnt_d.pol[i]  = (var_states_i[i].val == VAL_FALSE);
            end
        end
    end

    // chronological target, level 0 leaves the bin
    assign at_floor = (loc_lvl_i == '0);
    assign target   = at_floor ? '0 : loc_lvl_i - loc_lvl_t'(1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            ANALYZE_IDLE: begin
                // only a pending conflict starts analysis
                if (apply_analyze_i && |conflict_mask_i) begin
                    state_d = FIND_LEARNTC;
                end
            end
            FIND_LEARNTC: state_d = ADD_LEARNTC;
            ADD_LEARNTC:  state_d = ANALYZE_DONE;
            ANALYZE_DONE: state_d = ANALYZE_IDLE;
            default:      state_d = ANALYZE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q          <= ANALYZE_IDLE;
            add_learntc_en_o <= 1'b0;
            done_analyze_o   <= 1'b0;
        end else begin
            state_q          <= state_d;
            add_learntc_en_o <= (state_q == ADD_LEARNTC);
            done_analyze_o   <= (state_q == ANALYZE_DONE);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            bkt_loc_lvl_o <= '0;
            bkt_bin_o     <= 1'b0;
            bkt_lvl_o     <= '0;
        end else if (state_q == FIND_LEARNTC) begin
            bkt_loc_lvl_o <= target;
            bkt_bin_o     <= at_floor;
            bkt_lvl_o     <= base_lvl_q + lvl_t'(target);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FIND_LEARNTC) begin
            learnt_o <= learnt_d;
        end
    end

endmodule

`default_nettype wire

//--- hw/sat_bin_state.sv
`default_nettype none

module sat_bin_state
    import sat_state_pkg::*;
#(
    parameter int NUM_VARS = 8
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       base_lvl_en_i,
    input  wire lvl_t                 base_lvl_i,
    input  wire                       start_decision_i,
    input  wire                       apply_imply_i,
    input  wire imply_req_t           imply_req_i,
    input  wire                       apply_analyze_i,
    input  wire                       apply_bkt_i,
    output var_state_t [NUM_VARS-1:0] var_states_o,
    output lvl_t                      cur_lvl_o,
    output logic                      done_decision_o,
    output logic                      done_imply_o,
    output logic                      find_conflict_o,
    output logic                      add_learntc_en_o,
    output clause_t                   learnt_o,
    output logic                      done_analyze_o,
    output lvl_t                      bkt_lvl_o,
    output logic                      bkt_bin_o,
    output logic                      done_bkt_o,
    output logic                      all_assigned_o
);

    var_state_t [NUM_VARS-1:0] var_states;
    logic                      dec_valid;
    logic [NUM_VARS-1:0]       dec_index;
    loc_lvl_t                  loc_lvl;
    logic [NUM_VARS-1:0]       conflict_mask;
    loc_lvl_t                  bkt_loc_lvl;

    assign var_states_o = var_states;

    decision_decode #(.NUM_VARS(NUM_VARS)) u_decode (
        .clk             (clk),
        .rst             (rst),
        .start_decision_i(start_decision_i),
        .var_states_i    (var_states),
        .apply_bkt_i     (apply_bkt_i),
        .bkt_loc_lvl_i   (bkt_loc_lvl),
        .dec_valid_o     (dec_valid),
        .dec_index_o     (dec_index),
        .loc_lvl_o       (loc_lvl),
        .done_decision_o (done_decision_o),
        .all_assigned_o  (all_assigned_o)
    );

    var_state_exec #(.NUM_VARS(NUM_VARS)) u_exec (
        .clk            (clk),
        .rst            (rst),
        .dec_valid_i    (dec_valid),
        .dec_index_i    (dec_index),
        .loc_lvl_i      (loc_lvl),
        .apply_imply_i  (apply_imply_i),
        .imply_req_i    (imply_req_i),
        .apply_bkt_i    (apply_bkt_i),
        .bkt_loc_lvl_i  (bkt_loc_lvl),
        .var_states_o   (var_states),
        .conflict_mask_o(conflict_mask),
        .find_conflict_o(find_conflict_o),
        .done_imply_o   (done_imply_o),
        .done_bkt_o     (done_bkt_o)
    );

    bkt_result #(.NUM_VARS(NUM_VARS)) u_result (
        .clk             (clk),
        .rst             (rst),
        .var_states_i    (var_states),
        .conflict_mask_i (conflict_mask),
        .loc_lvl_i       (loc_lvl),
        .apply_analyze_i (apply_analyze_i),
        .base_lvl_en_i   (base_lvl_en_i),
        .base_lvl_i      (base_lvl_i),
        .cur_lvl_o       (cur_lvl_o),
        .learnt_o        (learnt_o),
        .add_learntc_en_o(add_learntc_en_o),
        .done_analyze_o  (done_analyze_o),
        .bkt_lvl_o       (bkt_lvl_o),
        .bkt_bin_o       (bkt_bin_o),
        .bkt_loc_lvl_o   (bkt_loc_lvl)
    );

endmodule

`default_nettype wire

//--- sim/sat_bin_state_sva.sv
`default_nettype none

module sat_bin_state_sva (
    input wire clk,
    input wire rst,
    input wire apply_bkt_i,
    input wire done_decision_o,
    input wire done_imply_o,
    input wire add_learntc_en_o,
    input wire done_analyze_o,
    input wire done_bkt_o,
    input wire find_conflict_o
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    // every done is a single cycle pulse
    a_dec_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_decision_o |=> !done_decision_o)
    else begin
        $error("done_decision_o longer than one cycle");
        fail_count++;
    end
    a_imp_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_imply_o |=> !done_imply_o)
    else begin
        $error("done_imply_o longer than one cycle");
        fail_count++;
    end
    a_ana_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_analyze_o |=> !done_analyze_o)
    else begin
        $error("done_analyze_o longer than one cycle");
        fail_count++;
    end
    a_bkt_pulse: assert property (@(posedge clk) disable iff (!rst)
        done_bkt_o |=> !done_bkt_o)
    else begin
        $error("done_bkt_o longer than one cycle");
        fail_count++;
    end

    a_learnt_then_done: assert property (@(posedge clk) disable iff (!rst)
        add_learntc_en_o |=> done_analyze_o)
    else begin
        $error("done_analyze_o did not follow");
        fail_count++;
    end
    a_done_after_learnt: assert property (@(posedge clk) disable iff (!rst)
        done_analyze_o |-> $past(add_learntc_en_o))
    else begin
        $error("done_analyze_o without clause");
        fail_count++;
    end

    a_bkt_done: assert property (@(posedge clk) disable iff (!rst)
        apply_bkt_i |=> done_bkt_o)
    else begin
        $error("done_bkt_o did not follow apply_bkt_i");
        fail_count++;
    end

    // sticky until backtrack
    a_conflict_fall: assert property (@(posedge clk) disable iff (!rst)
        $fell(find_conflict_o) |-> $past(apply_bkt_i))
    else begin
        $error("conflict cleared early");
        fail_count++;
    end

endmodule

bind sat_bin_state sat_bin_state_sva u_sva (
    .clk             (clk),
    .rst             (rst),
    .apply_bkt_i     (apply_bkt_i),
    .done_decision_o (done_decision_o),
    .done_imply_o    (done_imply_o),
    .add_learntc_en_o(add_learntc_en_o),
    .done_analyze_o  (done_analyze_o),
    .done_bkt_o      (done_bkt_o),
    .find_conflict_o (find_conflict_o)
);

`default_nettype wire

//--- sim/tb_sat_bin_state.sv
`default_nettype none

module tb_sat_bin_state
    import sat_state_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VARS = 8;
    localparam int NUM_OPS  = 400;
    localparam int WAIT_MAX = 12;

    logic clk;
    logic rst;
    logic base_lvl_en_i;
    lvl_t base_lvl_i;
    logic start_decision_i;
    logic apply_imply_i;
    imply_req_t imply_req_i;
    logic apply_analyze_i;
    logic apply_bkt_i;

    var_state_t [NUM_VARS-1:0] var_states_o;
    lvl_t cur_lvl_o;
    logic done_decision_o;
    logic done_imply_o;
    logic find_conflict_o;
    logic add_learntc_en_o;
    clause_t learnt_o;
    logic done_analyze_o;
    lvl_t bkt_lvl_o;
    logic bkt_bin_o;
    logic done_bkt_o;
    logic all_assigned_o;

    // reference model
    var_state_t [NUM_VARS-1:0] m_state;
    lvl_t m_base;
    loc_lvl_t m_loc;
    logic m_conflict;

    sat_bin_state #(.NUM_VARS(NUM_VARS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(NUM_OPS * 20 * 8);
        $display("watchdog expired before the operation sequence finished");
        $display(">>> FAIL");
        $fatal(1);
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    always @(negedge clk) begin
        if (DUT.u_sva.fail_count != 0) begin
            stop_run("a protocol assertion in the bound checker failed");
        end
    end

    task automatic check_states(input string name, input var_state_t [NUM_VARS-1:0] exp,
                                input var_state_t [NUM_VARS-1:0] act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run("variable state array differs from model");
        end
    endtask

    task automatic check_lvl(input string name, input lvl_t exp, input lvl_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run("level differs from model");
        end
    endtask

    task automatic check_clause(input string name, input clause_t exp, input clause_t act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            stop_run("learnt clause differs from model");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            stop_run("flag differs from model");
        end
    endtask

    // one cycle of an implication as the model sees it
    function automatic void model_imply(input imply_req_t req);
        var_val_t want;
        for (int i = 0; i < NUM_VARS; i++) begin
            want = req.pol[i] ? VAL_TRUE : VAL_FALSE;
            if (req.mask[i]) begin
                if (m_state[i].val == VAL_UNASSIGNED) begin
                    m_state[i].val     = want;
                    m_state[i].implied = 1'b1;
                    m_state[i].lvl     = m_loc;
                end else if (m_state[i].val != want) begin
                    m_conflict = 1'b1;
                end
            end
        end
    endfunction

    task automatic do_decision();
        logic was_full;
        int k;
        was_full = 1'b1;
        @(posedge clk);
        start_decision_i <= 1'b1;
        @(posedge clk);
        start_decision_i <= 1'b0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (was_full && m_state[i].val == VAL_UNASSIGNED) begin
                was_full           = 1'b0;
                m_loc              = m_loc + loc_lvl_t'(1);
                m_state[i].val     = VAL_FALSE;
                m_state[i].implied = 1'b0;
                m_state[i].lvl     = m_loc;
            end
        end
        for (k = 0; k < WAIT_MAX && !done_decision_o; k++) @(negedge clk);
        if (!done_decision_o) stop_run("no done_decision_o after a decision");
        check_states("decision", m_state, var_states_o);
        check_lvl("decision cur_lvl", m_base + lvl_t'(m_loc), cur_lvl_o);
        check_flag("decision all_assigned", was_full, all_assigned_o);
    endtask

    task automatic do_imply();
        imply_req_t req;
        int n;
        int cycles;
        n      = 1 + ($urandom % 3);
        cycles = 0;
        req    = imply_req_t'({$urandom, $urandom});
        @(posedge clk);
        apply_imply_i <= 1'b1;
        imply_req_i   <= req;
        forever begin
            @(posedge clk);
            model_imply(req);
            cycles++;
            if (cycles < n) req = imply_req_t'({$urandom, $urandom});
            imply_req_i <= req;
            @(negedge clk);
            if (done_imply_o) break;
            if (cycles > WAIT_MAX) stop_run("no done_imply_o during an implication burst");
        end
        // the request already driven is sampled once more
        @(posedge clk);
        model_imply(req);
        apply_imply_i <= 1'b0;
        @(negedge clk);
        check_states("imply", m_state, var_states_o);
        check_flag("imply conflict", m_conflict, find_conflict_o);
    endtask

    task automatic do_analyze_bkt();
        clause_t exp_cl;
        loc_lvl_t target;
        int k;
        exp_cl = '0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (m_state[i].val != VAL_UNASSIGNED && !m_state[i].implied) begin
                exp_cl.mask[i] = 1'b1;
                exp_cl.pol[i]  = (m_state[i].val == VAL_FALSE);
            end
        end
        target = (m_loc == 0) ? loc_lvl_t'(0) : m_loc - loc_lvl_t'(1);
        @(posedge clk);
        apply_analyze_i <= 1'b1;
        @(posedge clk);
        apply_analyze_i <= 1'b0;
        for (k = 0; k < WAIT_MAX && !add_learntc_en_o; k++) @(negedge clk);
        if (!add_learntc_en_o) stop_run("no add_learntc_en_o after analysis start");
        check_clause("analyze learnt", exp_cl, learnt_o);
        for (k = 0; k < WAIT_MAX && !done_analyze_o; k++) @(negedge clk);
        if (!done_analyze_o) stop_run("no done_analyze_o after the learnt clause");
        check_lvl("analyze bkt_lvl", m_base + lvl_t'(target), bkt_lvl_o);
        check_flag("analyze bkt_bin", m_loc == 0, bkt_bin_o);
        @(posedge clk);
        apply_bkt_i <= 1'b1;
        @(posedge clk);
        apply_bkt_i <= 1'b0;
        for (int i = 0; i < NUM_VARS; i++) begin
            if (m_state[i].lvl > target) m_state[i] = '0;
        end
        m_loc      = target;
        m_conflict = 1'b0;
        for (k = 0; k < WAIT_MAX && !done_bkt_o; k++) @(negedge clk);
        if (!done_bkt_o) stop_run("no done_bkt_o after backtrack");
        check_states("backtrack", m_state, var_states_o);
        check_lvl("backtrack cur_lvl", m_base + lvl_t'(m_loc), cur_lvl_o);
        check_flag("backtrack conflict", 1'b0, find_conflict_o);
    endtask

    task automatic do_base_load();
        lvl_t b;
        b = lvl_t'($urandom);
        @(posedge clk);
        base_lvl_en_i <= 1'b1;
        base_lvl_i    <= b;
        @(posedge clk);
        base_lvl_en_i <= 1'b0;
        m_base = b;
        @(negedge clk);
        check_lvl("base cur_lvl", m_base + lvl_t'(m_loc), cur_lvl_o);
    endtask

    initial begin
        int pick;
        void'($urandom(49));
        rst              = 1'b0;
        base_lvl_en_i    = 1'b0;
        base_lvl_i       = '0;
        start_decision_i = 1'b0;
        apply_imply_i    = 1'b0;
        imply_req_i      = '0;
        apply_analyze_i  = 1'b0;
        apply_bkt_i      = 1'b0;
        m_state          = '0;
        m_base           = '0;
        m_loc            = '0;
        m_conflict       = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_states("reset", m_state, var_states_o);
        for (int op = 0; op < NUM_OPS; op++) begin
            pick = $urandom % 10;
            if (m_conflict) do_analyze_bkt();
            else if (pick < 4) do_decision();
            else if (pick < 9) do_imply();
            else do_base_load();
        end
        if (DUT.u_sva.fail_count != 0) begin
            stop_run("a protocol assertion in the bound checker failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sat_bin_state.f
hw/sat_state_pkg.sv
hw/decision_decode.sv
hw/var_state_exec.sv
hw/bkt_result.sv
hw/sat_bin_state.sv
sim/sat_bin_state_sva.sv
sim/tb_sat_bin_state.sv

//--- Bender.yml
package:
  name: sat_bin_state

sources:
  - files:
      - hw/sat_state_pkg.sv
      - hw/decision_decode.sv
      - hw/var_state_exec.sv
      - hw/bkt_result.sv
      - hw/sat_bin_state.sv
  - target: simulation
    files:
      - sim/sat_bin_state_sva.sv
      - sim/tb_sat_bin_state.sv
